// ==== display_ctrl.f ====
source/lcd_pkg.sv
source/screen_pkg.sv
source/message_rom.sv
source/screen_sequencer.sv
source/lcd_writer.sv
source/display_ctrl.sv
tests/display_ctrl_props.sv
tests/display_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the display controller testbench

SRCS := $(shell cat display_ctrl.f)

.PHONY: all run clean

all: run

obj_dir/Vdisplay_ctrl_tb: display_ctrl.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module display_ctrl_tb \
		-f display_ctrl.f

run: obj_dir/Vdisplay_ctrl_tb
	./obj_dir/Vdisplay_ctrl_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failures found" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "All tests passed!" sim.log || { echo "FAIL: run did not complete"; exit 1; }
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

// ==== tests/display_ctrl_tb.sv ====
`timescale 1ns/10ps

module display_ctrl_tb import lcd_pkg::*, screen_pkg::*; ();

    localparam int SETUP_CYCLES     = 1;
    localparam int EN_CYCLES        = 3;
    localparam int HOLD_CYCLES      = 5;
    localparam int LONG_HOLD_CYCLES = 20;
    localparam int CLK_PERIOD       = 40;
    localparam int SCREEN_BUDGET    = 26;  // Screens drawn over the run, with margin
    localparam int TIMEOUT_CYCLES   =
        SCREEN_BUDGET * 40 * (SETUP_CYCLES + EN_CYCLES + LONG_HOLD_CYCLES + 6);

    logic       clk;
    logic       rst;
    logic       start;
    logic       finished;
    enc_stage_t stage;
    lcd_word_t  lcd;
    logic       en;
    logic       busy;

    lcd_word_t  exp_q[$];   // Words the model expects for one screen
    lcd_word_t  got_q[$];   // Words latched by the display
    time        last_fall;
    logic       last_long;  // Previous word was clear or home
    logic       have_prev;
    enc_stage_t shown;      // Stage on the compression screen

    display_ctrl #(
        .SETUP_CYCLES     (SETUP_CYCLES),
        .EN_CYCLES        (EN_CYCLES),
        .HOLD_CYCLES      (HOLD_CYCLES),
        .LONG_HOLD_CYCLES (LONG_HOLD_CYCLES)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .finished (finished),
        .stage    (stage),
        .lcd      (lcd),
        .en       (en),
        .busy     (busy)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // The display latches on the falling edge of en
    always @(negedge en) begin
        got_q.push_back(lcd);
        last_fall = $time;
        last_long = !lcd.rs && (lcd.data == LCD_CLEAR || lcd.data == LCD_HOME);
        have_prev = 1'b1;
    end

    always @(posedge en) begin
        int gap;
        if (have_prev) begin
            gap = int'(($time - last_fall) / CLK_PERIOD);
            check_value(gap >= (last_long ? LONG_HOLD_CYCLES : HOLD_CYCLES), 1,
                        "settle time before next enable");
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the display did not finish its screens in %0d cycles",
                 TIMEOUT_CYCLES);
        $display("Test failures found");
        $fatal(1, "Watchdog expired");
    end

    function automatic int expected_blocks(input logic [3:0] code);
        case (code)
            4'd1:    return 2;
            4'd2:    return 4;
            4'd3:    return 6;
            4'd4:    return 8;
            4'd5:    return 11;
            4'd6:    return 14;
            4'd8:    return 16;   // Done fills the line
            default: return 0;
        endcase
    endfunction

    function automatic logic [3:0] rand_stage();
        logic [3:0] code;
        do
            code = 4'($urandom % 16);
        while (code == 4'd7);  // Error code is applied on purpose only
        return code;
    endfunction

    task automatic push_cmd(input lcd_byte_t code);
        exp_q.push_back('{rs: 1'b0, rw: 1'b0, data: code});
    endtask

    task automatic push_text(input string txt);
        for (int i = 0; i < txt.len(); i++)
            exp_q.push_back('{rs: 1'b1, rw: 1'b0, data: txt[i]});
    endtask

    task automatic build_screen(input screen_t scr, input enc_stage_t stg);
        exp_q.delete();
        push_cmd(LCD_CLEAR);
        push_cmd(LCD_HOME);
        case (scr)
            SCR_INIT: begin
                push_cmd(LCD_FUNC_SET);
                push_cmd(LCD_DISP_ON);
                push_cmd(LCD_ENTRY_MODE);
            end
            SCR_TITLE: begin
                push_text("HUFFMAN ENCODING");
                push_cmd(LCD_LINE2_ADDR);
                push_text("PRESS START");
            end
            SCR_SELECT: push_text("COMPRESSION");
            SCR_COMP: begin
                push_text("COMPRESSION");
                push_cmd(LCD_LINE2_ADDR);
                for (int i = 0; i < expected_blocks(stg); i++)
                    exp_q.push_back('{rs: 1'b1, rw: 1'b0, data: CHAR_BLOCK});
            end
            SCR_FINISH: push_text("FINISH");
            default:    push_text("ERROR");
        endcase
    endtask

    // Waits for one whole draw, busy marks its start and end
    task automatic expect_screen(input screen_t scr, input enc_stage_t stg);
        build_screen(scr, stg);
        @(negedge clk);
        while (!busy)
            @(negedge clk);
        while (busy)
            @(negedge clk);
        check_value(got_q.size(), exp_q.size(), {scr.name(), " word count"});
        foreach (exp_q[i])
            check_value(got_q[i], exp_q[i], $sformatf("%s word %0d", scr.name(), i));
        got_q.delete();
    endtask

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value(busy, 1'b0, "busy while idle");
            check_value(en, 1'b0, "en pulse while idle");
            check_value(got_q.size(), 0, "words sent while idle");
        end
    endtask

    task automatic drive(input logic s, input logic f, input logic [3:0] code);
        @(posedge clk);
        start    <= s;
        finished <= f;
        stage    <= enc_stage_t'(code);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst      <= 1'b1;
        start    <= 1'b0;
        finished <= 1'b0;
        stage    <= STG_IDLE;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        got_q.delete();
        have_prev = 1'b0;
        shown     = STG_IDLE;
    endtask

    initial begin
        logic [3:0] code;
        rst       = 1'b1;
        start     = 1'b0;
        finished  = 1'b0;
        stage     = STG_IDLE;
        last_fall = 0;
        last_long = 1'b0;
        have_prev = 1'b0;
        shown     = STG_IDLE;
        void'($urandom(32'hd312d6f2));
        apply_reset();

        expect_screen(SCR_INIT, STG_IDLE);
        expect_screen(SCR_TITLE, STG_IDLE);
        expect_screen(SCR_SELECT, STG_IDLE);

        drive(1'b0, 1'b0, rand_stage());  // Select waits for start
        idle_check(4 + $urandom % 40);
        code = rand_stage();
        drive(1'b1, 1'b0, code);
        shown = enc_stage_t'(code);
        expect_screen(SCR_COMP, shown);

        for (int r = 0; r < 12; r++) begin
            if ($urandom % 3 == 0)
                code = shown;  // Repeat must not redraw
            else
                code = rand_stage();
            drive(1'($urandom % 2), 1'b0, code);
            if (code != shown) begin
                shown = enc_stage_t'(code);
                expect_screen(SCR_COMP, shown);
            end else begin
                idle_check(4 + $urandom % 20);
            end
        end

        drive(1'b0, 1'b1, shown);
        expect_screen(SCR_FINISH, shown);
        for (int r = 0; r < 6; r++) begin
            drive(1'($urandom % 2), 1'($urandom % 2), 4'($urandom % 16));
            idle_check(4 + $urandom % 20);
        end

        // Error has priority over finished
        apply_reset();
        expect_screen(SCR_INIT, STG_IDLE);
        expect_screen(SCR_TITLE, STG_IDLE);
        expect_screen(SCR_SELECT, STG_IDLE);
        code = rand_stage();
        drive(1'b1, 1'b0, code);
        expect_screen(SCR_COMP, enc_stage_t'(code));
        drive(1'b0, 1'b1, STG_ERROR);
        expect_screen(SCR_ERROR, STG_ERROR);
        idle_check(10);

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== tests/display_ctrl_props.sv ====
`timescale 1ns/10ps

module display_ctrl_props import lcd_pkg::*; #(
    parameter int EN_CYCLES = 12
) (
    input logic      clk,
    input logic      rst,
    input lcd_word_t lcd,
    input logic      en,
    input logic      req,
    input logic      ack
);

    int en_len;  // Sampled cycles with en high

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            en_len <= 0;
        else if (en)
            en_len <= en_len + 1;
        else
            en_len <= 0;
    end

    en_width: assert property (@(posedge clk) disable iff (rst)
        $fell(en) |-> en_len == EN_CYCLES)
        else $error("en pulse lasted %0d cycles", en_len);

    bus_stable: assert property (@(posedge clk) disable iff (rst) en |-> $stable(lcd))
        else $error("lcd changed while en was high");

    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
        else $error("ack rose without req");

    ack_held: assert property (@(posedge clk) disable iff (rst) ack && req |=> ack)
        else $error("ack dropped before req fell");

endmodule

bind lcd_writer display_ctrl_props #(.EN_CYCLES(EN_CYCLES)) props0 (
    .clk (clk),
    .rst (rst),
    .lcd (lcd),
    .en  (en),
    .req (req),
    .ack (ack)
);

// ==== source/display_ctrl.sv ====
`timescale 1ns/10ps

module display_ctrl import lcd_pkg::*, screen_pkg::*; #(
    parameter int SETUP_CYCLES     = 1,      // Cycles at 25 MHz
    parameter int EN_CYCLES        = 12,
    parameter int HOLD_CYCLES      = 1000,   // 40 us
    parameter int LONG_HOLD_CYCLES = 40000   // 1.6 ms for clear and home
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       finished,
    input  enc_stage_t stage,
    output lcd_word_t  lcd,
    output logic       en,
    output logic       busy
);

    screen_t    screen;
    msg_index_t index;
    enc_stage_t shown_stage;
    lcd_word_t  rom_word;
    lcd_word_t  word;
    logic       last;
    logic       req;
    logic       ack;

    screen_sequencer seq0 (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .finished    (finished),
        .stage       (stage),
        .screen      (screen),
        .index       (index),
        .shown_stage (shown_stage),
        .rom_word    (rom_word),
        .last        (last),
        .word        (word),
        .req         (req),
        .ack         (ack),
        .busy        (busy)
    );

    message_rom rom0 (
        .screen      (screen),
        .index       (index),
        .shown_stage (shown_stage),
        .word        (rom_word),
        .last        (last)
    );

    lcd_writer #(
        .SETUP_CYCLES     (SETUP_CYCLES),
        .EN_CYCLES        (EN_CYCLES),
        .HOLD_CYCLES      (HOLD_CYCLES),
        .LONG_HOLD_CYCLES (LONG_HOLD_CYCLES)
    ) wr0 (
        .clk  (clk),
        .rst  (rst),
        .word (word),
        .req  (req),
        .ack  (ack),
        .lcd  (lcd),
        .en   (en)
    );

endmodule

// ==== source/lcd_writer.sv ====
`timescale 1ns/10ps

module lcd_writer import lcd_pkg::*; #(
    parameter int SETUP_CYCLES     = 1,
    parameter int EN_CYCLES        = 12,
    parameter int HOLD_CYCLES      = 1000,
    parameter int LONG_HOLD_CYCLES = 40000
) (
    input  logic      clk,
    input  logic      rst,
    input  lcd_word_t word,
    input  logic      req,
    output logic      ack,
    output lcd_word_t lcd,
    output logic      en
);

    localparam int MAX_SHORT  = (SETUP_CYCLES > EN_CYCLES) ? SETUP_CYCLES : EN_CYCLES;
    localparam int MAX_HOLD   = (HOLD_CYCLES > LONG_HOLD_CYCLES) ? HOLD_CYCLES : LONG_HOLD_CYCLES;
    localparam int MAX_CYCLES = (MAX_SHORT > MAX_HOLD) ? MAX_SHORT : MAX_HOLD;
    localparam int CNT_W      = $clog2(MAX_CYCLES + 1);

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_SETUP,  // Bus valid, en still low
        WR_PULSE,
        WR_HOLD,   // Display executes the write
        WR_ACK
    } wr_phase_t;

    wr_phase_t        phase;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= WR_IDLE;
            cnt   <= '0;
            lcd   <= '0;
            en    <= 1'b0;
            ack   <= 1'b0;
        end else begin
            case (phase)
                WR_IDLE: begin
                    if (req && !ack) begin
                        lcd   <= word;
                        cnt   <= CNT_W'(SETUP_CYCLES - 1);
                        phase <= WR_SETUP;
                    end
                end
                WR_SETUP: begin
                    if (cnt == '0) begin
                        en    <= 1'b1;
                        cnt   <= CNT_W'(EN_CYCLES - 1);
                        phase <= WR_PULSE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                WR_PULSE: begin
                    if (cnt == '0) begin
                        en    <= 1'b0;  // Display latches on this falling edge
                        cnt   <= is_long_cmd(lcd) ? CNT_W'(LONG_HOLD_CYCLES - 1)
                                                  : CNT_W'(HOLD_CYCLES - 1);
                        phase <= WR_HOLD;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                WR_HOLD: begin
                    if (cnt == '0) begin
                        ack   <= 1'b1;
                        phase <= WR_ACK;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                WR_ACK: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        phase <= WR_IDLE;
                    end
                end
                default: phase <= WR_IDLE;
            endcase
        end
    end

endmodule

// ==== source/screen_sequencer.sv ====
`timescale 1ns/10ps

module screen_sequencer import lcd_pkg::*, screen_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       finished,
    input  enc_stage_t stage,
    output screen_t    screen,
    output msg_index_t index,
    output enc_stage_t shown_stage,
    input  lcd_word_t  rom_word,
    input  logic       last,
    output lcd_word_t  word,
    output logic       req,
    input  logic       ack,
    output logic       busy
);

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_REQ,           // req high, waiting for ack
        DRAW_WAIT_ACK_LOW,
        DRAW_NEXT           // Load word from the ROM
    } draw_state_t;

    draw_state_t draw_state;
    logic        init_pending;  // INIT screen still to be drawn
    logic        last_word;     // Word in flight closes the screen
    logic        draw_go;
    screen_t     next_screen;
    enc_stage_t  next_stage;

    // Screen order, only evaluated between draws
    always_comb begin
        draw_go     = 1'b0;
        next_screen = screen;
        next_stage  = shown_stage;
        if (draw_state == DRAW_IDLE) begin
            if (init_pending) begin
                draw_go = 1'b1;
            end else begin
                case (screen)
                    SCR_INIT: begin
                        draw_go     = 1'b1;
                        next_screen = SCR_TITLE;
                    end
                    SCR_TITLE: begin
                        draw_go     = 1'b1;
                        next_screen = SCR_SELECT;
                    end
                    SCR_SELECT: begin
                        if (start) begin
                            draw_go     = 1'b1;
                            next_screen = SCR_COMP;
                            next_stage  = stage;
                        end
                    end
                    SCR_COMP: begin
                        if (stage == STG_ERROR) begin  // Error wins over finished
                            draw_go     = 1'b1;
                            next_screen = SCR_ERROR;
                        end else if (finished) begin
                            draw_go     = 1'b1;
                            next_screen = SCR_FINISH;
                        end else if (stage != shown_stage) begin
                            draw_go    = 1'b1;
                            next_stage = stage;
                        end
                    end
                    default: draw_go = 1'b0;  // FINISH and ERROR hold until reset
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            draw_state   <= DRAW_IDLE;
            screen       <= SCR_INIT;
            shown_stage  <= STG_IDLE;
            index        <= '0;
            init_pending <= 1'b1;
            last_word    <= 1'b0;
            req          <= 1'b0;
            busy         <= 1'b0;
        end else begin
            case (draw_state)
                DRAW_IDLE: begin
                    if (draw_go) begin
                        screen       <= next_screen;
                        shown_stage  <= next_stage;
                        init_pending <= 1'b0;
                        index        <= '0;
                        busy         <= 1'b1;
                        draw_state   <= DRAW_NEXT;
                    end
                end
                DRAW_NEXT: begin
                    req        <= 1'b1;  // Word is registered on the same edge
                    last_word  <= last;
                    draw_state <= DRAW_REQ;
                end
                DRAW_REQ: begin
                    if (ack) begin
                        req        <= 1'b0;
                        draw_state <= DRAW_WAIT_ACK_LOW;
                    end
                end
                DRAW_WAIT_ACK_LOW: begin
                    if (!ack) begin
                        if (last_word) begin
                            busy       <= 1'b0;
                            draw_state <= DRAW_IDLE;
                        end else begin
                            index      <= index + msg_index_t'(1);
                            draw_state <= DRAW_NEXT;
                        end
                    end
                end
                default: draw_state <= DRAW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (draw_state == DRAW_NEXT)
            word <= rom_word;  // Held until the next word is loaded
    end

endmodule

// ==== source/message_rom.sv ====
`timescale 1ns/10ps

module message_rom import lcd_pkg::*, screen_pkg::*; (
    input  screen_t    screen,
    input  msg_index_t index,
    input  enc_stage_t shown_stage,
    output lcd_word_t  word,
    output logic       last
);

    // Text is right-justified, first character in the highest byte used
    localparam logic [8*16-1:0] TXT_TITLE  = "HUFFMAN ENCODING";
    localparam logic [8*16-1:0] TXT_PRESS  = "PRESS START";
    localparam logic [8*16-1:0] TXT_COMP   = "COMPRESSION";
    localparam logic [8*16-1:0] TXT_FINISH = "FINISH";
    localparam logic [8*16-1:0] TXT_ERROR  = "ERROR";

    localparam int LEN_TITLE  = LCD_LINE_CHARS;
    localparam int LEN_PRESS  = 11;
    localparam int LEN_COMP   = 11;
    localparam int LEN_FINISH = 6;
    localparam int LEN_ERROR  = 5;

    function automatic lcd_byte_t text_char(
        input logic [8*16-1:0] txt,
        input int              len,
        input int              pos
    );
        return txt[8*(len-1-pos) +: 8];
    endfunction

    bar_len_t   bar_len;
    msg_index_t last_idx;
    int         pos;

    always_comb begin
        case (shown_stage)
            STG_IDLE:  bar_len = 5'd0;
            STG_HISTO: bar_len = 5'd2;
            STG_FLV:   bar_len = 5'd4;
            STG_HTREE: bar_len = 5'd6;
            STG_CBS:   bar_len = 5'd8;
            STG_TRN:   bar_len = 5'd11;
            STG_SPI:   bar_len = 5'd14;
            STG_DONE:  bar_len = bar_len_t'(LCD_LINE_CHARS);
            default:   bar_len = 5'd0;
        endcase
    end

    // Index of the final word, clear and home take positions 0 and 1
    always_comb begin
        case (screen)
            SCR_INIT:   last_idx = 6'd4;
            SCR_TITLE:  last_idx = msg_index_t'(2 + LEN_TITLE + LEN_PRESS);
            SCR_SELECT: last_idx = msg_index_t'(1 + LEN_COMP);
            SCR_COMP:   last_idx = msg_index_t'(2 + LEN_COMP) + msg_index_t'(bar_len);
            SCR_FINISH: last_idx = msg_index_t'(1 + LEN_FINISH);
            SCR_ERROR:  last_idx = msg_index_t'(1 + LEN_ERROR);
            default:    last_idx = 6'd1;
        endcase
    end

    assign last = (index == last_idx);

    always_comb begin
        pos  = int'(index) - 2;  // Offset past clear and home
        word = lcd_char(CHAR_SPACE);
        if (index == 6'd0) begin
            word = lcd_cmd(LCD_CLEAR);
        end else if (index == 6'd1) begin
            word = lcd_cmd(LCD_HOME);
        end else if (index <= last_idx) begin
            case (screen)
                SCR_INIT: begin
                    case (pos)
                        0:       word = lcd_cmd(LCD_FUNC_SET);
                        1:       word = lcd_cmd(LCD_DISP_ON);
                        default: word = lcd_cmd(LCD_ENTRY_MODE);
                    endcase
                end
                SCR_TITLE: begin
                    if (pos < LEN_TITLE)
                        word = lcd_char(text_char(TXT_TITLE, LEN_TITLE, pos));
                    else if (pos == LEN_TITLE)
                        word = lcd_cmd(LCD_LINE2_ADDR);
                    else
                        word = lcd_char(text_char(TXT_PRESS, LEN_PRESS, pos - LEN_TITLE - 1));
                end
                SCR_SELECT: word = lcd_char(text_char(TXT_COMP, LEN_COMP, pos));
                SCR_COMP: begin
                    if (pos < LEN_COMP)
                        word = lcd_char(text_char(TXT_COMP, LEN_COMP, pos));
                    else if (pos == LEN_COMP)
                        word = lcd_cmd(LCD_LINE2_ADDR);
                    else
                        word = lcd_char(CHAR_BLOCK);  // Progress bar
                end
                SCR_FINISH: word = lcd_char(text_char(TXT_FINISH, LEN_FINISH, pos));
                SCR_ERROR:  word = lcd_char(text_char(TXT_ERROR, LEN_ERROR, pos));
                default:    word = lcd_char(CHAR_SPACE);
            endcase
        end
    end

endmodule

// ==== source/screen_pkg.sv ====
package screen_pkg;

    // Screens shown on the front panel
    typedef enum logic [2:0] {
        SCR_INIT,
        SCR_TITLE,
        SCR_SELECT,
        SCR_COMP,
        SCR_FINISH,
        SCR_ERROR
    } screen_t;

    // Stage reported by the Huffman encoder
    typedef enum logic [3:0] {
        STG_IDLE  = 4'd0,
        STG_HISTO = 4'd1,  // Histogram
        STG_FLV   = 4'd2,  // Frequency list
        STG_HTREE = 4'd3,  // Tree build
        STG_CBS   = 4'd4,  // Codebook
        STG_TRN   = 4'd5,  // Translation
        STG_SPI   = 4'd6,  // Output over SPI
        STG_ERROR = 4'd7,
        STG_DONE  = 4'd8
    } enc_stage_t;

    typedef logic [5:0] msg_index_t;  // Word position within one screen

    typedef logic [4:0] bar_len_t;  // Progress blocks, 0 to 16

endpackage

// ==== source/lcd_pkg.sv ====
package lcd_pkg;

    typedef logic [7:0] lcd_byte_t;  // One data or command byte

    // One bus write to the HD44780
    typedef struct packed {
        logic      rs;    // High for character data
        logic      rw;    // Always low, the bus is write-only
        lcd_byte_t data;
    } lcd_word_t;

    localparam lcd_byte_t LCD_CLEAR      = 8'h01;
    localparam lcd_byte_t LCD_HOME       = 8'h02;
    localparam lcd_byte_t LCD_FUNC_SET   = 8'h38;  // 8-bit bus, 2 lines, 5x8 font
    localparam lcd_byte_t LCD_DISP_ON    = 8'h0C;  // Display on, no cursor
    localparam lcd_byte_t LCD_ENTRY_MODE = 8'h06;  // Increment, no shift
    localparam lcd_byte_t LCD_LINE2_ADDR = 8'hC0;  // DDRAM address 0x40

    localparam lcd_byte_t CHAR_SPACE = 8'h20;
    localparam lcd_byte_t CHAR_BLOCK = 8'hFF;  // Full 5x8 block

    localparam int LCD_LINE_CHARS = 16;

    function automatic lcd_word_t lcd_cmd(input lcd_byte_t code);
        return '{rs: 1'b0, rw: 1'b0, data: code};
    endfunction

    function automatic lcd_word_t lcd_char(input lcd_byte_t code);
        return '{rs: 1'b1, rw: 1'b0, data: code};
    endfunction

    // Clear and home need the long execution time
    function automatic logic is_long_cmd(input lcd_word_t w);
        return !w.rs && (w.data == LCD_CLEAR || w.data == LCD_HOME);
    endfunction

endpackage
